//--- hdl/regfile_pkg.sv
package regfile_pkg;

	//////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////

	localparam int data_width  = 32;
	localparam int addr_width  = 5;
	localparam int reg_count   = 32;
	localparam int stack_reg   = 31; // r31 is banked between the two modes.
	localparam int sridx_width = 10;

	//////////////////////////////////////////////////
	// opcodes and system-register indices
	//////////////////////////////////////////////////

	localparam logic [5:0] opcode_misc = 6'h30;

	localparam logic [1:0] misc_mfsr = 2'd1;
	localparam logic [1:0] misc_mtsr = 2'd2;

	localparam logic [sridx_width-1:0] sridx_system_mode  = 10'd128;
	localparam logic [sridx_width-1:0] sridx_kernel_stack = 10'd169;
	localparam logic [sridx_width-1:0] sridx_user_stack   = 10'd170;

	localparam logic mode_kernel = 1'b0;
	localparam logic mode_user   = 1'b1;

	// an mtsr reaches write-back this many cycles after issue.
	localparam int mtsr_delay = 3;

	//////////////////////////////////////////////////
	// instruction word
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0]            opcode;
		logic [addr_width-1:0] rt;
		logic [addr_width-1:0] ra;
		logic [addr_width-1:0] rb;
		logic [10:0]           unused;
	} reg_format_t;

	typedef struct packed {
		logic [5:0]             opcode;
		logic [addr_width-1:0]  rt;
		logic [addr_width-1:0]  ra;
		logic [sridx_width-1:0] sridx;
		logic [1:0]             misc_sel;
		logic [3:0]             unused;
	} misc_format_t;

	typedef union packed {
		reg_format_t  reg_format;
		misc_format_t misc_format;
	} instr_word_t;

endpackage

//--- hdl/misc_control.sv
`timescale 1ns/1ps

module misc_control
	import regfile_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue,
	input  instr_word_t            instruction,

	output logic [addr_width-1:0]  ra_addr,
	output logic [addr_width-1:0]  rb_addr,
	output logic [addr_width-1:0]  rt_addr,

	output logic                   mfsr_strobe,
	output logic [sridx_width-1:0] mfsr_sridx,
	output logic                   mtsr_apply,
	output logic [sridx_width-1:0] mtsr_sridx,

	output logic                   do_hazard
);

	logic                   is_misc;
	logic [1:0]             misc_sel;
	logic [sridx_width-1:0] sridx;
	logic                   mtsr_issue;

	logic [mtsr_delay-1:0]  stage_valid;
	logic [sridx_width-1:0] stage_sridx [mtsr_delay];

	logic [1:0]             hazard_count;

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////

	// the register fields are always valid as read addresses.
	always_comb begin
		ra_addr = instruction.reg_format.ra;
		rb_addr = instruction.reg_format.rb;
		rt_addr = instruction.reg_format.rt;
	end

	always_comb begin
		is_misc  = issue && (instruction.misc_format.opcode == opcode_misc);
		misc_sel = instruction.misc_format.misc_sel;
		sridx    = instruction.misc_format.sridx;

		mfsr_strobe = is_misc && (misc_sel == misc_mfsr); // served in the issue cycle.
		mfsr_sridx  = sridx;
		mtsr_issue  = is_misc && (misc_sel == misc_mtsr);
	end

	//////////////////////////////////////////////////
	// mtsr pipeline
	//////////////////////////////////////////////////

	// the index travels with its valid bit down to write-back.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			stage_valid <= '0;
			for (int i = 0; i < mtsr_delay; i++) begin
				stage_sridx[i] <= '0;
			end
		end else begin
			stage_valid <= {stage_valid[mtsr_delay-2:0], mtsr_issue};
			stage_sridx[0] <= sridx;
			for (int i = 1; i < mtsr_delay; i++) begin
				stage_sridx[i] <= stage_sridx[i-1];
			end
		end
	end

	assign mtsr_apply = stage_valid[mtsr_delay-1];
	assign mtsr_sridx = stage_sridx[mtsr_delay-1];

	//////////////////////////////////////////////////
	// hazard counter
	//////////////////////////////////////////////////

	// loaded at the issue edge and empty again at the apply edge.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			hazard_count <= 2'd0;
		end else if (mtsr_issue) begin
			hazard_count <= 2'(mtsr_delay);
		end else if (hazard_count != 2'd0) begin
			hazard_count <= hazard_count - 2'd1;
		end
	end

	assign do_hazard = (hazard_count != 2'd0);

endmodule

//--- hdl/gpr_bank.sv
`timescale 1ns/1ps

module gpr_bank
	import regfile_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  enable_reg_fetch,
	input  logic                  enable_reg_write,

	input  logic [addr_width-1:0] ra_addr,
	input  logic [addr_width-1:0] rb_addr,
	input  logic [addr_width-1:0] rt_addr,

	input  logic                  do_reg_write,
	input  logic [addr_width-1:0] write_reg_addr,
	input  logic [data_width-1:0] write_reg_data,

	input  logic                  do_ra_write,
	input  logic [addr_width-1:0] write_ra_addr,
	input  logic [data_width-1:0] write_ra_data,

	input  logic                  swap_load,
	input  logic [data_width-1:0] banked_value,

	output logic [data_width-1:0] reg_ra_data,
	output logic [data_width-1:0] reg_rb_data,
	output logic [data_width-1:0] reg_rt_data,
	output logic [data_width-1:0] stack_value
);

	logic [data_width-1:0] regs [reg_count];

	//////////////////////////////////////////////////
	// write ports
	//////////////////////////////////////////////////

	// later assignments win, so port B beats port A and the swap beats both.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (enable_reg_write && do_reg_write) begin
				regs[write_reg_addr] <= write_reg_data;
			end
			if (enable_reg_write && do_ra_write) begin
				regs[write_ra_addr] <= write_ra_data;
			end
			if (swap_load) begin
				regs[stack_reg] <= banked_value;
			end
		end
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// a fetch sees the array before this edge's writes.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			reg_ra_data <= '0;
			reg_rb_data <= '0;
			reg_rt_data <= '0;
		end else if (enable_reg_fetch) begin
			reg_ra_data <= regs[ra_addr];
			reg_rb_data <= regs[rb_addr];
			reg_rt_data <= regs[rt_addr];
		end
	end

	assign stack_value = regs[stack_reg]; // current r31 for the banking logic.

endmodule

//--- hdl/system_regs.sv
`timescale 1ns/1ps

module system_regs
	import regfile_pkg::*;
(
	input  logic                   clock,
	input  logic                   reset,

	input  logic                   mfsr_strobe,
	input  logic [sridx_width-1:0] mfsr_sridx,
	input  logic                   mtsr_apply,
	input  logic [sridx_width-1:0] mtsr_sridx,

	input  logic [data_width-1:0]  write_reg_data,
	input  logic [data_width-1:0]  stack_value,

	output logic [data_width-1:0]  system_reg,
	output logic                   system_mode,
	output logic                   swap_load,
	output logic [data_width-1:0]  banked_value
);

	logic mode_write;
	logic new_mode;

	//////////////////////////////////////////////////
	// mode change
	//////////////////////////////////////////////////

	always_comb begin
		mode_write = mtsr_apply && (mtsr_sridx == sridx_system_mode);
		new_mode   = write_reg_data[0];
		swap_load  = mode_write && (new_mode != system_mode); // r31 swaps only on a real change.
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			system_mode  <= mode_kernel;
			banked_value <= '0;
		end else begin
			if (mode_write) begin
				system_mode <= new_mode;
			end
			if (swap_load) begin
				banked_value <= stack_value;
			end
		end
	end

	//////////////////////////////////////////////////
	// mfsr result
	//////////////////////////////////////////////////

	// the live r31 belongs to the current mode and the banked copy to the other.
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			system_reg <= '0;
		end else if (mfsr_strobe) begin
			case (mfsr_sridx)
				sridx_system_mode: begin
					system_reg <= {{(data_width-1){1'b0}}, system_mode};
				end
				sridx_kernel_stack: begin
					system_reg <= (system_mode == mode_kernel) ? stack_value : banked_value;
				end
				sridx_user_stack: begin
					system_reg <= (system_mode == mode_user) ? stack_value : banked_value;
				end
				default: begin
					system_reg <= system_reg; // an unknown index keeps the last result.
				end
			endcase
		end
	end

endmodule

//--- hdl/regfile_unit.sv
`timescale 1ns/1ps

module regfile_unit
	import regfile_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue,
	input  instr_word_t           instruction,
	input  logic                  enable_reg_fetch,
	input  logic                  enable_reg_write,

	input  logic                  do_reg_write,
	input  logic [addr_width-1:0] write_reg_addr,
	input  logic [data_width-1:0] write_reg_data,

	input  logic                  do_ra_write,
	input  logic [addr_width-1:0] write_ra_addr,
	input  logic [data_width-1:0] write_ra_data,

	output logic [data_width-1:0] reg_ra_data,
	output logic [data_width-1:0] reg_rb_data,
	output logic [data_width-1:0] reg_rt_data,
	output logic [data_width-1:0] system_reg,
	output logic                  system_mode,
	output logic                  do_hazard
);

	logic [addr_width-1:0]  ra_addr;
	logic [addr_width-1:0]  rb_addr;
	logic [addr_width-1:0]  rt_addr;

	logic                   mfsr_strobe;
	logic [sridx_width-1:0] mfsr_sridx;
	logic                   mtsr_apply;
	logic [sridx_width-1:0] mtsr_sridx;

	logic                   swap_load;
	logic [data_width-1:0]  banked_value;
	logic [data_width-1:0]  stack_value;

	misc_control i_control (
		.clock       (clock),
		.reset       (reset),
		.issue       (issue),
		.instruction (instruction),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.rt_addr     (rt_addr),
		.mfsr_strobe (mfsr_strobe),
		.mfsr_sridx  (mfsr_sridx),
		.mtsr_apply  (mtsr_apply),
		.mtsr_sridx  (mtsr_sridx),
		.do_hazard   (do_hazard)
	);

	gpr_bank i_gpr (
		.clock            (clock),
		.reset            (reset),
		.enable_reg_fetch (enable_reg_fetch),
		.enable_reg_write (enable_reg_write),
		.ra_addr          (ra_addr),
		.rb_addr          (rb_addr),
		.rt_addr          (rt_addr),
		.do_reg_write     (do_reg_write),
		.write_reg_addr   (write_reg_addr),
		.write_reg_data   (write_reg_data),
		.do_ra_write      (do_ra_write),
		.write_ra_addr    (write_ra_addr),
		.write_ra_data    (write_ra_data),
		.swap_load        (swap_load),
		.banked_value     (banked_value),
		.reg_ra_data      (reg_ra_data),
		.reg_rb_data      (reg_rb_data),
		.reg_rt_data      (reg_rt_data),
		.stack_value      (stack_value)
	);

	// the write-back data of port A is also the mtsr source.
	system_regs i_sysregs (
		.clock          (clock),
		.reset          (reset),
		.mfsr_strobe    (mfsr_strobe),
		.mfsr_sridx     (mfsr_sridx),
		.mtsr_apply     (mtsr_apply),
		.mtsr_sridx     (mtsr_sridx),
		.write_reg_data (write_reg_data),
		.stack_value    (stack_value),
		.system_reg     (system_reg),
		.system_mode    (system_mode),
		.swap_load      (swap_load),
		.banked_value   (banked_value)
	);

endmodule

//--- dv/regfile_unit_checker.sv
`timescale 1ns/1ps

module regfile_unit_checker
	import regfile_pkg::*;
(
	input logic        clock,
	input logic        reset,
	input logic        issue,
	input instr_word_t instruction,
	input logic        do_hazard
);

	logic misc_issue;
	logic mtsr_issue;

	assign misc_issue = issue && (instruction.misc_format.opcode == opcode_misc);
	assign mtsr_issue = misc_issue && (instruction.misc_format.misc_sel == misc_mtsr);

	//////////////////////////////////////////////////
	// hazard timing
	//////////////////////////////////////////////////

	// three cycles high, then low again at the write-back edge.
	hazard_window: assert property (@(posedge clock) disable iff (reset)
		mtsr_issue |=> do_hazard ##1 do_hazard ##1 do_hazard ##1 !do_hazard)
		else $error("do_hazard window after mtsr issue is not three cycles");

	no_issue_in_hazard: assert property (@(posedge clock) disable iff (reset)
		do_hazard |-> !misc_issue)
		else $error("misc instruction issued while do_hazard is high");

	hazard_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !do_hazard)
		else $error("do_hazard is high right after reset");

endmodule

bind regfile_unit regfile_unit_checker i_checker (
	.clock       (clock),
	.reset       (reset),
	.issue       (issue),
	.instruction (instruction),
	.do_hazard   (do_hazard)
);

//--- dv/regfile_unit_tb.sv
`timescale 1ns/1ps

module regfile_unit_tb
	import regfile_pkg::*;
();

	typedef struct {
		logic                  issue;
		instr_word_t           instruction;
		logic                  fetch;
		logic                  write;
		logic                  a_en;
		logic [addr_width-1:0] a_addr;
		logic [data_width-1:0] a_data;
		logic                  b_en;
		logic [addr_width-1:0] b_addr;
		logic [data_width-1:0] b_data;
		logic [data_width-1:0] exp_ra;
		logic [data_width-1:0] exp_rb;
		logic [data_width-1:0] exp_rt;
		logic [data_width-1:0] exp_sysreg;
		logic                  exp_mode;
		logic                  exp_hazard;
		logic [3:0]            mask; // reads, system_reg, mode, hazard.
	} step_t;

	logic clock = 1'b0;
	logic reset;
	logic issue;
	instr_word_t instruction;
	logic enable_reg_fetch;
	logic enable_reg_write;
	logic do_reg_write;
	logic [addr_width-1:0] write_reg_addr;
	logic [data_width-1:0] write_reg_data;
	logic do_ra_write;
	logic [addr_width-1:0] write_ra_addr;
	logic [data_width-1:0] write_ra_data;
	logic [data_width-1:0] reg_ra_data;
	logic [data_width-1:0] reg_rb_data;
	logic [data_width-1:0] reg_rt_data;
	logic [data_width-1:0] system_reg;
	logic system_mode;
	logic do_hazard;

	step_t steps[$];
	logic [31:0] rng = 32'd32768;
	int cycles = 0;
	int cycle_limit = 1000;

	// reference model of the architectural state.
	logic [data_width-1:0] m_regs [reg_count];
	logic [data_width-1:0] m_banked = '0;
	logic m_mode = mode_kernel;
	logic [data_width-1:0] m_ra = '0;
	logic [data_width-1:0] m_rb = '0;
	logic [data_width-1:0] m_rt = '0;
	logic [data_width-1:0] m_sysreg = '0;
	int mtsr_at = -100;
	int last_mtsr = -100;
	logic [sridx_width-1:0] mtsr_idx = '0;

	regfile_unit i_dut (.*);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the stimulus table did not finish in %0d cycles.", cycle_limit);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic step_t blank_step();
		step_t s;
		s = '{default: '0};
		s.instruction = '0;
		s.instruction.reg_format.opcode = 6'h01; // any opcode other than misc.
		s.mask = 4'hf;
		return s;
	endfunction

	function automatic step_t fetch_step(input logic [4:0] rt, input logic [4:0] ra,
			input logic [4:0] rb);
		step_t s;
		s = blank_step();
		s.fetch = 1'b1;
		s.instruction.reg_format.rt = rt;
		s.instruction.reg_format.ra = ra;
		s.instruction.reg_format.rb = rb;
		return s;
	endfunction

	function automatic step_t misc_step(input logic [1:0] sel, input logic [sridx_width-1:0] idx);
		step_t s;
		s = blank_step();
		s.issue = 1'b1;
		s.instruction.misc_format.opcode = opcode_misc;
		s.instruction.misc_format.sridx = idx;
		s.instruction.misc_format.misc_sel = sel;
		return s;
	endfunction

	// works out what the outputs show after the edge that samples this step.
	task automatic add_step(input step_t s);
		int k;
		logic [data_width-1:0] old_r31;
		k = steps.size();
		old_r31 = m_regs[stack_reg];
		if (s.fetch) begin
			m_ra = m_regs[s.instruction.reg_format.ra];
			m_rb = m_regs[s.instruction.reg_format.rb];
			m_rt = m_regs[s.instruction.reg_format.rt];
		end
		if (s.issue && s.instruction.misc_format.opcode == opcode_misc) begin
			if (s.instruction.misc_format.misc_sel == misc_mfsr) begin
				case (s.instruction.misc_format.sridx)
					sridx_system_mode: m_sysreg = 32'(m_mode);
					sridx_kernel_stack: m_sysreg = (m_mode == mode_kernel) ? old_r31 : m_banked;
					sridx_user_stack: m_sysreg = (m_mode == mode_user) ? old_r31 : m_banked;
					default: m_sysreg = m_sysreg;
				endcase
			end else if (s.instruction.misc_format.misc_sel == misc_mtsr) begin
				mtsr_at = k + mtsr_delay;
				last_mtsr = k;
				mtsr_idx = s.instruction.misc_format.sridx;
			end
		end
		if (s.write && s.a_en) m_regs[s.a_addr] = s.a_data;
		if (s.write && s.b_en) m_regs[s.b_addr] = s.b_data;
		if (k == mtsr_at && mtsr_idx == sridx_system_mode) begin
			if (s.a_data[0] != m_mode) begin
				m_regs[stack_reg] = m_banked; // the swap wins over a write to r31.
				m_banked = old_r31;
			end
			m_mode = s.a_data[0];
		end
		s.exp_ra = m_ra;
		s.exp_rb = m_rb;
		s.exp_rt = m_rt;
		s.exp_sysreg = m_sysreg;
		s.exp_mode = m_mode;
		s.exp_hazard = (k - last_mtsr) < mtsr_delay;
		steps.push_back(s);
	endtask

	// the new mode rides on port A data at the write-back step.
	task automatic mtsr_sequence(input logic mode_value, input logic clobber_r31);
		step_t s;
		logic [31:0] r;
		add_step(misc_step(misc_mtsr, sridx_system_mode));
		repeat (mtsr_delay - 1) add_step(blank_step());
		r = xorshift32();
		s = blank_step();
		s.write = clobber_r31;
		s.a_en = clobber_r31;
		s.a_addr = 5'(stack_reg);
		s.a_data = {r[31:1], mode_value};
		add_step(s);
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic drive_step(input step_t s);
		issue = s.issue;
		instruction = s.instruction;
		enable_reg_fetch = s.fetch;
		enable_reg_write = s.write;
		do_reg_write = s.a_en;
		write_reg_addr = s.a_addr;
		write_reg_data = s.a_data;
		do_ra_write = s.b_en;
		write_ra_addr = s.b_addr;
		write_ra_data = s.b_data;
	endtask

	task automatic check_step(input step_t s);
		if (s.mask[0]) begin
			compare_value("reg_ra_data", reg_ra_data, s.exp_ra);
			compare_value("reg_rb_data", reg_rb_data, s.exp_rb);
			compare_value("reg_rt_data", reg_rt_data, s.exp_rt);
		end
		if (s.mask[1]) compare_value("system_reg", system_reg, s.exp_sysreg);
		if (s.mask[2]) compare_value("system_mode", 32'(system_mode), 32'(s.exp_mode));
		if (s.mask[3]) compare_value("do_hazard", 32'(do_hazard), 32'(s.exp_hazard));
	endtask

	//////////////////////////////////////////////////
	// stimulus table and run
	//////////////////////////////////////////////////

	initial begin
		step_t s;
		for (int i = 0; i < reg_count; i++) m_regs[i] = '0;
		reset = 1'b1;
		drive_step(blank_step());

		add_step(fetch_step(5'd3, 5'd1, 5'd2));
		for (int i = 1; i < 16; i++) begin
			s = fetch_step(5'(i), 5'(i), 5'(i + 16)); // reads the old values.
			s.write = 1'b1;
			s.a_en = 1'b1;
			s.a_addr = 5'(i);
			s.a_data = xorshift32();
			s.b_en = 1'b1;
			s.b_addr = 5'(i + 16);
			s.b_data = xorshift32();
			add_step(s);
			add_step(fetch_step(5'(i), 5'(i), 5'(i + 16)));
		end
		s = fetch_step(5'd7, 5'd8, 5'd9);
		s.fetch = 1'b0;
		add_step(s);
		s = blank_step();
		s.write = 1'b1;
		s.a_en = 1'b1;
		s.a_addr = 5'd5;
		s.a_data = xorshift32();
		s.b_en = 1'b1;
		s.b_addr = 5'd5;
		s.b_data = xorshift32();
		add_step(s);
		add_step(fetch_step(5'd5, 5'd5, 5'd31));
		add_step(misc_step(misc_mfsr, sridx_system_mode));
		add_step(misc_step(misc_mfsr, sridx_user_stack));
		add_step(misc_step(misc_mfsr, sridx_kernel_stack));
		add_step(misc_step(misc_mfsr, 10'd5));

		mtsr_sequence(mode_user, 1'b1);
		add_step(fetch_step(5'd31, 5'd31, 5'd31));
		add_step(misc_step(misc_mfsr, sridx_user_stack));
		add_step(misc_step(misc_mfsr, sridx_kernel_stack));
		add_step(misc_step(misc_mfsr, sridx_system_mode));
		s = blank_step();
		s.write = 1'b1;
		s.b_en = 1'b1;
		s.b_addr = 5'd31;
		s.b_data = xorshift32();
		add_step(s);
		mtsr_sequence(mode_user, 1'b0);
		add_step(fetch_step(5'd31, 5'd30, 5'd29));
		mtsr_sequence(mode_kernel, 1'b0);
		add_step(fetch_step(5'd31, 5'd31, 5'd31));
		add_step(misc_step(misc_mfsr, sridx_kernel_stack));
		add_step(misc_step(misc_mfsr, sridx_user_stack));
		add_step(misc_step(misc_mfsr, sridx_system_mode));
		cycle_limit = steps.size() + 8 + 20;

		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		for (int k = 0; k <= steps.size(); k++) begin
			@(posedge clock);
			#1;
			if (k < steps.size()) drive_step(steps[k]);
			else drive_step(blank_step());
			#97;
			if (k > 0) check_step(steps[k - 1]);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- filelist.f
hdl/regfile_pkg.sv
hdl/misc_control.sv
hdl/gpr_bank.sv
hdl/system_regs.sv
hdl/regfile_unit.sv
dv/regfile_unit_checker.sv
dv/regfile_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; success only when the pass message shows up.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f filelist.f --top-module regfile_unit_tb -Mdir obj_dir -o regfile_unit_sim &&
./obj_dir/regfile_unit_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
echo "run.sh: test passed" ||
{ echo "run.sh: test did not pass"; exit 1; }
